//--- verilog/dbg_noc_pkg.sv
// Debug NoC definitions
// USB word, 16 bit flit with type, command codes, header layout,
// register indices and control register bits
package dbg_noc_pkg;

   typedef logic [15:0] fx2_word_t; // One word on the USB FIFO bus

   // Flit type encoding as on the 16 bit debug NoC
   typedef enum logic [1:0] {
      FLIT_BODY   = 2'b00,
      FLIT_HEAD   = 2'b01,
      FLIT_LAST   = 2'b10,
      FLIT_SINGLE = 2'b11
   } flit_type_t;

   typedef struct packed {
      flit_type_t ftype;
      logic [15:0] data;
   } dbg_flit_t; // 18 bit flit

   // Command codes in header bits 15..12
   localparam logic [3:0] CMD_REG_RD = 4'h1;
   localparam logic [3:0] CMD_REG_WR = 4'h2;
   localparam logic [3:0] CMD_MEM_RD = 4'h3;
   localparam logic [3:0] CMD_MEM_WR = 4'h4;
   localparam logic [3:0] CMD_ERR    = 4'hf;

   localparam int HDR_CMD_MSB = 15;
   localparam int HDR_CMD_LSB = 12;
   localparam int HDR_CNT_MSB = 3; // Payload word count
   localparam int HDR_CNT_LSB = 0;

   localparam logic [15:0] REG_ID   = 16'h0000; // Read only
   localparam logic [15:0] REG_CTRL = 16'h0001;

   localparam int CTRL_HALT_BIT  = 0;
   localparam int CTRL_RESET_BIT = 1;
   localparam int CTRL_START_BIT = 2; // Pulse only, not stored

endpackage

//--- verilog/pgas_mem_pkg.sv
// PGAS memory bus definitions
// Wishbone widths shared by the debug master and the global SRAM
package pgas_mem_pkg;

   typedef logic [31:0] wb_adr_t; // Byte address
   typedef logic [31:0] wb_dat_t;
   typedef logic [3:0]  wb_sel_t;

   // All four byte lanes, debug accesses are full words
   localparam wb_sel_t WB_SEL_ALL = 4'hf;

   // Byte address bits below the word index
   localparam int WB_BYTE_OFS_BITS = 2;

endpackage

//--- verilog/sync_fifo.sv
// Synchronous FIFO
// Circular buffer with first word fall through, generic in the payload
// type and the depth
`timescale 1ns/10ps

module sync_fifo #(
   parameter type payload_t = logic [15:0],
   parameter int  DEPTH     = 8
) (
   input  logic     clk,
   input  logic     arst_n_i,
   input  logic     push_i,
   input  payload_t push_data_i,
   output logic     full_o,
   input  logic     pop_i,
   output payload_t pop_data_o,
   output logic     empty_o
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);
   localparam logic [AW:0]   CNT_FULL = (AW + 1)'(DEPTH);

   payload_t mem [DEPTH]; // Storage, no reset
   logic [AW-1:0] wr_ptr_q, rd_ptr_q;
   logic [AW:0]   count_q; // Fill level

   assign full_o     = (count_q == CNT_FULL);
   assign empty_o    = (count_q == '0);
   assign pop_data_o = mem[rd_ptr_q]; // Oldest entry

   always_ff @(posedge clk) begin
      if (push_i) mem[wr_ptr_q] <= push_data_i;
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
         if (pop_i)  rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
         case ({push_i, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q; // Both or none
         endcase
      end
   end

   // Users must look at the flags
   assert property (@(posedge clk) disable iff (!arst_n_i) !(push_i && full_o))
      else $error("sync_fifo: push while full");
   assert property (@(posedge clk) disable iff (!arst_n_i) !(pop_i && empty_o))
      else $error("sync_fifo: pop while empty");

endmodule

//--- verilog/usb_fifo_bridge.sv
// USB FIFO bridge
// Master of an FX2 slave FIFO port. Incoming 16 bit words are typed
// into debug NoC flits from the header count, response flits go back
// to the IN endpoint with a packet end strobe after the last word.
`timescale 1ns/10ps

module usb_fifo_bridge
   import dbg_noc_pkg::*;
#(
   parameter int FIFO_DEPTH = 8
) (
   input  logic      clk,
   input  logic      arst_n_i,
   // FX2 side
   input  fx2_word_t fx2_fd_i,
   input  logic      fx2_epout_empty_i,
   input  logic      fx2_epin_full_i,
   output fx2_word_t fx2_fd_o,
   output logic      fx2_fd_oe_o,
   output logic      fx2_slrd_o,
   output logic      fx2_slwr_o,
   output logic      fx2_sloe_o,
   output logic      fx2_pktend_o,
   output logic [1:0] fx2_fifoadr_o,
   // Debug NoC side
   output dbg_flit_t req_flit_o,
   output logic      req_valid_o,
   input  logic      req_take_i,
   input  dbg_flit_t rsp_flit_i,
   input  logic      rsp_valid_i,
   output logic      rsp_take_o
);

   localparam logic [1:0] EP_OUT_ADR = 2'b00; // EP2, host to device
   localparam logic [1:0] EP_IN_ADR  = 2'b10; // EP6, device to host

   typedef enum logic [1:0] {BR_READ, BR_WRITE, BR_PKTEND} br_state_t;
   br_state_t state_q;

   fx2_word_t in_word;
   dbg_flit_t out_flit;
   logic in_full, in_empty, out_full, out_empty;
   logic [3:0] remain_q; // Words left in current request, 0 = header next

   sync_fifo #(.payload_t(fx2_word_t), .DEPTH(FIFO_DEPTH)) u_in_fifo (
      .clk(clk), .arst_n_i(arst_n_i),
      .push_i(fx2_slrd_o), .push_data_i(fx2_fd_i), .full_o(in_full),
      .pop_i(req_valid_o & req_take_i), .pop_data_o(in_word), .empty_o(in_empty));

   sync_fifo #(.payload_t(dbg_flit_t), .DEPTH(FIFO_DEPTH)) u_out_fifo (
      .clk(clk), .arst_n_i(arst_n_i),
      .push_i(rsp_valid_i & rsp_take_o), .push_data_i(rsp_flit_i), .full_o(out_full),
      .pop_i(fx2_slwr_o), .pop_data_o(out_flit), .empty_o(out_empty));

   // Strobes decode from the state, so they cannot overlap
   assign fx2_slrd_o    = (state_q == BR_READ) && !in_full && !fx2_epout_empty_i;
   assign fx2_slwr_o    = (state_q == BR_WRITE) && !out_empty && !fx2_epin_full_i;
   assign fx2_fd_oe_o   = fx2_slwr_o; // Board drives the bus only while writing
   assign fx2_fd_o      = out_flit.data;
   assign fx2_sloe_o    = (state_q == BR_READ);
   assign fx2_pktend_o  = (state_q == BR_PKTEND);
   assign fx2_fifoadr_o = (state_q == BR_READ) ? EP_OUT_ADR : EP_IN_ADR;
   assign rsp_take_o    = !out_full;
   assign req_valid_o   = !in_empty;

   // Flit type from the header count
   always_comb begin
      req_flit_o.data = in_word;
      if (remain_q == 4'd0) begin
         req_flit_o.ftype = (in_word[HDR_CNT_MSB:HDR_CNT_LSB] == 4'd0) ? FLIT_SINGLE : FLIT_HEAD;
      end else begin
         req_flit_o.ftype = (remain_q == 4'd1) ? FLIT_LAST : FLIT_BODY;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q  <= BR_READ;
         remain_q <= 4'd0;
      end else begin
         if (req_valid_o && req_take_i) begin
            remain_q <= (remain_q == 4'd0) ? in_word[HDR_CNT_MSB:HDR_CNT_LSB] : remain_q - 4'd1;
         end
         case (state_q)
            BR_READ:  if (!out_empty) state_q <= BR_WRITE; // Responses first
            BR_WRITE: begin
               // Stay on the IN endpoint until the packet is closed
               if (fx2_slwr_o && (out_flit.ftype == FLIT_LAST || out_flit.ftype == FLIT_SINGLE))
                  state_q <= BR_PKTEND;
            end
            default:  state_q <= out_empty ? BR_READ : BR_WRITE; // One cycle pktend
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!arst_n_i) !(fx2_slrd_o && fx2_slwr_o))
      else $error("usb_fifo_bridge: slrd and slwr together");

endmodule

//--- verilog/dbg_ctrl_unit.sv
// Debug control unit
// Collects one command packet, runs register or memory access and
// sends back exactly one response packet. Holds the system control
// register and is the Wishbone master towards the PGAS memory.
`timescale 1ns/10ps

module dbg_ctrl_unit
   import dbg_noc_pkg::*;
   import pgas_mem_pkg::*;
#(
   parameter logic [15:0] SYSTEM_ID = 16'hce75
) (
   input  logic      clk,
   input  logic      arst_n_i,
   input  dbg_flit_t req_flit_i,
   input  logic      req_valid_i,
   output logic      req_take_o,
   output dbg_flit_t rsp_flit_o,
   output logic      rsp_valid_o,
   input  logic      rsp_take_i,
   output wb_adr_t   wb_adr_o,
   output wb_dat_t   wb_dat_o,
   output wb_sel_t   wb_sel_o,
   output logic      wb_we_o,
   output logic      wb_cyc_o,
   output logic      wb_stb_o,
   input  wb_dat_t   wb_dat_i,
   input  logic      wb_ack_i,
   output logic      sys_halt_o,
   output logic      cpu_reset_o,
   output logic      cpu_start_o
);

   typedef enum logic [2:0] {S_HDR, S_PAY, S_EXEC, S_WB, S_RSP} state_t;
   state_t state_q;

   logic [3:0]  cmd_q, cnt_q; // From the request header
   fx2_word_t   op_q [4];     // First four payload words
   logic [2:0]  idx_q;        // Payload store index, saturates at 4
   fx2_word_t   rsp_word_q [3];
   logic [1:0]  rsp_len_q, ridx_q;
   logic        halt_q, reset_q, start_q, cyc_q, we_q;
   logic [3:0]  exp_cnt;
   logic        cmd_known, idx_ok, cmd_ok, is_mem;
   fx2_word_t   ctrl_val, reg_val;

   function automatic fx2_word_t mk_hdr(input logic [3:0] cmd, input logic [3:0] cnt);
      fx2_word_t w;
      w = '0;
      w[HDR_CMD_MSB:HDR_CMD_LSB] = cmd;
      w[HDR_CNT_MSB:HDR_CNT_LSB] = cnt;
      return w;
   endfunction

   // Command check
   always_comb begin
      exp_cnt   = 4'd0;
      cmd_known = 1'b1;
      case (cmd_q)
         CMD_REG_RD: exp_cnt = 4'd1;
         CMD_REG_WR: exp_cnt = 4'd2;
         CMD_MEM_RD: exp_cnt = 4'd2;
         CMD_MEM_WR: exp_cnt = 4'd4;
         default:    cmd_known = 1'b0;
      endcase
      idx_ok = 1'b1;
      if (cmd_q == CMD_REG_RD) idx_ok = (op_q[0] == REG_ID) || (op_q[0] == REG_CTRL);
      if (cmd_q == CMD_REG_WR) idx_ok = (op_q[0] == REG_CTRL); // ID is read only
      cmd_ok = cmd_known && (cnt_q == exp_cnt) && idx_ok;
      is_mem = (cmd_q == CMD_MEM_RD) || (cmd_q == CMD_MEM_WR);
      ctrl_val = '0;
      ctrl_val[CTRL_HALT_BIT]  = halt_q;
      ctrl_val[CTRL_RESET_BIT] = reset_q;
      reg_val = (op_q[0] == REG_ID) ? SYSTEM_ID : ctrl_val;
   end

   // Payload, operands and response words
   always_ff @(posedge clk) begin
      if (state_q == S_HDR && req_valid_i) begin
         cmd_q <= req_flit_i.data[HDR_CMD_MSB:HDR_CMD_LSB];
         cnt_q <= req_flit_i.data[HDR_CNT_MSB:HDR_CNT_LSB];
      end
      if (state_q == S_PAY && req_valid_i && idx_q != 3'd4) op_q[idx_q[1:0]] <= req_flit_i.data;
      if (state_q == S_EXEC) begin
         wb_adr_o <= {op_q[0], op_q[1]};
         wb_dat_o <= {op_q[2], op_q[3]};
         we_q     <= (cmd_q == CMD_MEM_WR);
         rsp_word_q[1] <= reg_val;
         rsp_len_q     <= 2'd1; // Header only
         rsp_word_q[0] <= mk_hdr(cmd_ok ? cmd_q : CMD_ERR, 4'd0);
         if (cmd_ok && cmd_q == CMD_REG_RD) begin
            rsp_word_q[0] <= mk_hdr(CMD_REG_RD, 4'd1);
            rsp_len_q     <= 2'd2;
         end
         if (cmd_ok && cmd_q == CMD_MEM_RD) begin
            rsp_word_q[0] <= mk_hdr(CMD_MEM_RD, 4'd2);
            rsp_len_q     <= 2'd3;
         end
      end
      if (state_q == S_WB && wb_ack_i) begin
         rsp_word_q[1] <= wb_dat_i[31:16]; // High word first
         rsp_word_q[2] <= wb_dat_i[15:0];
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= S_HDR;
         idx_q   <= 3'd0;
         ridx_q  <= 2'd0;
         halt_q  <= 1'b0;
         reset_q <= 1'b0;
         start_q <= 1'b0;
         cyc_q   <= 1'b0;
      end else begin
         start_q <= 1'b0;
         case (state_q)
            S_HDR: if (req_valid_i) begin
               idx_q   <= 3'd0;
               state_q <= (req_flit_i.ftype == FLIT_SINGLE) ? S_EXEC : S_PAY;
            end
            S_PAY: if (req_valid_i) begin
               if (idx_q != 3'd4) idx_q <= idx_q + 3'd1;
               if (req_flit_i.ftype == FLIT_LAST) state_q <= S_EXEC; // Extra words dropped
            end
            S_EXEC: begin
               if (cmd_ok && cmd_q == CMD_REG_WR) begin
                  halt_q  <= op_q[1][CTRL_HALT_BIT];
                  reset_q <= op_q[1][CTRL_RESET_BIT];
                  start_q <= op_q[1][CTRL_START_BIT];
               end
               cyc_q   <= cmd_ok && is_mem;
               state_q <= (cmd_ok && is_mem) ? S_WB : S_RSP;
            end
            S_WB: if (wb_ack_i) begin
               cyc_q   <= 1'b0;
               state_q <= S_RSP;
            end
            default: if (rsp_take_i) begin
               ridx_q <= (ridx_q == rsp_len_q - 2'd1) ? 2'd0 : ridx_q + 2'd1;
               if (ridx_q == rsp_len_q - 2'd1) state_q <= S_HDR;
            end
         endcase
      end
   end

   // Response flit typing
   always_comb begin
      rsp_flit_o.data = rsp_word_q[ridx_q];
      if (rsp_len_q == 2'd1)               rsp_flit_o.ftype = FLIT_SINGLE;
      else if (ridx_q == 2'd0)             rsp_flit_o.ftype = FLIT_HEAD;
      else if (ridx_q == rsp_len_q - 2'd1) rsp_flit_o.ftype = FLIT_LAST;
      else                                 rsp_flit_o.ftype = FLIT_BODY;
   end

   assign req_take_o  = (state_q == S_HDR) || (state_q == S_PAY);
   assign rsp_valid_o = (state_q == S_RSP);
   assign wb_sel_o    = WB_SEL_ALL;
   assign wb_we_o     = we_q;
   assign wb_cyc_o    = cyc_q;
   assign wb_stb_o    = cyc_q; // Single access per cycle
   assign sys_halt_o  = halt_q;
   assign cpu_reset_o = reset_q;
   assign cpu_start_o = start_q;

   // Classic cycle, slave must see stb until it acks
   assert property (@(posedge clk) disable iff (!arst_n_i) wb_stb_o && !wb_ack_i |=> wb_stb_o)
      else $error("dbg_ctrl_unit: stb dropped before ack");

endmodule

//--- verilog/wb_sram_sp.sv
// Global PGAS memory
// Single port SRAM on a classic Wishbone cycle. Byte select writes,
// registered read data and ack one cycle after stb. Upper address
// bits are discarded, so the memory repeats over the address space.
`timescale 1ns/10ps

module wb_sram_sp
   import pgas_mem_pkg::*;
#(
   parameter int MEMORY_SIZE = 1024 // In 32 bit words, power of two
) (
   input  logic    clk,
   input  logic    arst_n_i,
   input  wb_adr_t wb_adr_i,
   input  wb_dat_t wb_dat_i,
   input  wb_sel_t wb_sel_i,
   input  logic    wb_we_i,
   input  logic    wb_cyc_i,
   input  logic    wb_stb_i,
   output wb_dat_t wb_dat_o,
   output logic    wb_ack_o
);

   localparam int AW = $clog2(MEMORY_SIZE);

   wb_dat_t mem [MEMORY_SIZE];
   logic [AW-1:0] word_adr;
   logic access;

   assign word_adr = wb_adr_i[WB_BYTE_OFS_BITS +: AW]; // Word aligned, truncated
   assign access   = wb_cyc_i && wb_stb_i && !wb_ack_o; // No second ack on held stb

   always_ff @(posedge clk) begin
      if (access) begin
         if (wb_we_i) begin
            for (int b = 0; b < 4; b++) begin
               if (wb_sel_i[b]) mem[word_adr][8*b +: 8] <= wb_dat_i[8*b +: 8];
            end
         end
         wb_dat_o <= mem[word_adr]; // Old data on writes
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) wb_ack_o <= 1'b0;
      else           wb_ack_o <= access;
   end

   // Master keeps cyc and stb up while the ack is out
   assert property (@(posedge clk) disable iff (!arst_n_i) wb_ack_o |-> (wb_cyc_i && wb_stb_i))
      else $error("wb_sram_sp: ack without request");

endmodule

//--- verilog/system_pgas_dbg_top.sv
// PGAS debug subsystem
// USB FIFO bridge, debug control unit and global PGAS SRAM on one clock
`timescale 1ns/10ps

module system_pgas_dbg_top
   import dbg_noc_pkg::*;
   import pgas_mem_pkg::*;
#(
   parameter int          MEMORY_SIZE = 1024,
   parameter logic [15:0] SYSTEM_ID   = 16'hce75,
   parameter int          FIFO_DEPTH  = 8
) (
   input  logic       clk,
   input  logic       arst_n_i,
   input  fx2_word_t  fx2_fd_i,
   input  logic       fx2_epout_empty_i,
   input  logic       fx2_epin_full_i,
   output fx2_word_t  fx2_fd_o,
   output logic       fx2_fd_oe_o, // Tristate enable for the board wrapper
   output logic       fx2_slrd_o,
   output logic       fx2_slwr_o,
   output logic       fx2_sloe_o,
   output logic       fx2_pktend_o,
   output logic [1:0] fx2_fifoadr_o,
   output logic       sys_halt_o,
   output logic       cpu_reset_o,
   output logic       cpu_start_o
);

   // Debug NoC link between bridge and control unit
   dbg_flit_t req_flit, rsp_flit;
   logic      req_valid, req_take, rsp_valid, rsp_take;

   // Wishbone to the PGAS memory
   wb_adr_t wb_adr;
   wb_dat_t wb_dat_w, wb_dat_r;
   wb_sel_t wb_sel;
   logic    wb_we, wb_cyc, wb_stb, wb_ack;

   usb_fifo_bridge #(.FIFO_DEPTH(FIFO_DEPTH)) u_bridge (
      .clk(clk), .arst_n_i(arst_n_i),
      .fx2_fd_i(fx2_fd_i), .fx2_epout_empty_i(fx2_epout_empty_i),
      .fx2_epin_full_i(fx2_epin_full_i), .fx2_fd_o(fx2_fd_o), .fx2_fd_oe_o(fx2_fd_oe_o),
      .fx2_slrd_o(fx2_slrd_o), .fx2_slwr_o(fx2_slwr_o), .fx2_sloe_o(fx2_sloe_o),
      .fx2_pktend_o(fx2_pktend_o), .fx2_fifoadr_o(fx2_fifoadr_o),
      .req_flit_o(req_flit), .req_valid_o(req_valid), .req_take_i(req_take),
      .rsp_flit_i(rsp_flit), .rsp_valid_i(rsp_valid), .rsp_take_o(rsp_take));

   dbg_ctrl_unit #(.SYSTEM_ID(SYSTEM_ID)) u_ctrl (
      .clk(clk), .arst_n_i(arst_n_i),
      .req_flit_i(req_flit), .req_valid_i(req_valid), .req_take_o(req_take),
      .rsp_flit_o(rsp_flit), .rsp_valid_o(rsp_valid), .rsp_take_i(rsp_take),
      .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w), .wb_sel_o(wb_sel), .wb_we_o(wb_we),
      .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack),
      .sys_halt_o(sys_halt_o), .cpu_reset_o(cpu_reset_o), .cpu_start_o(cpu_start_o));

   wb_sram_sp #(.MEMORY_SIZE(MEMORY_SIZE)) u_gram (
      .clk(clk), .arst_n_i(arst_n_i),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel), .wb_we_i(wb_we),
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack));

endmodule

//--- sim/tb_pgas_dbg.sv
// Testbench for the PGAS debug subsystem
// FX2 host model with random flags, command packets and expected
// responses from a stimulus file, control output checks
`timescale 1ns/10ps

module tb_pgas_dbg
   import dbg_noc_pkg::*;
();

   localparam logic [1:0] EP2_ADR = 2'b00; // FIFOADR of the OUT endpoint
   localparam logic [1:0] EP6_ADR = 2'b10; // FIFOADR of the IN endpoint

   logic clk, arst_n_i;
   fx2_word_t fx2_fd_i, fx2_fd_o;
   logic fx2_epout_empty_i, fx2_epin_full_i, fx2_fd_oe_o;
   logic fx2_slrd_o, fx2_slwr_o, fx2_sloe_o, fx2_pktend_o;
   logic [1:0] fx2_fifoadr_o;
   logic sys_halt_o, cpu_reset_o, cpu_start_o;

   logic [255:0] test_name [$]; // Test tables from the file
   fx2_word_t req_words [$], exp_words [$];
   int req_len [$], exp_len [$];
   fx2_word_t host_q [$];       // Words the host still has to send
   fx2_word_t got_words [$];    // Captured IN words
   int got_len [$];             // Packet lengths, split at pktend
   int cur_len, start_count, start_exp, err_count, tests_failed, cycles, cycle_limit;
   int seed;
   logic halt_exp, reset_exp, rd_fire;
   logic [31:0] rnd;

   system_pgas_dbg_top #(.MEMORY_SIZE(1024), .SYSTEM_ID(16'hce75), .FIFO_DEPTH(8)) dut0 (
      .clk(clk), .arst_n_i(arst_n_i),
      .fx2_fd_i(fx2_fd_i), .fx2_epout_empty_i(fx2_epout_empty_i),
      .fx2_epin_full_i(fx2_epin_full_i), .fx2_fd_o(fx2_fd_o), .fx2_fd_oe_o(fx2_fd_oe_o),
      .fx2_slrd_o(fx2_slrd_o), .fx2_slwr_o(fx2_slwr_o), .fx2_sloe_o(fx2_sloe_o),
      .fx2_pktend_o(fx2_pktend_o), .fx2_fifoadr_o(fx2_fifoadr_o),
      .sys_halt_o(sys_halt_o), .cpu_reset_o(cpu_reset_o), .cpu_start_o(cpu_start_o));

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk; // 4 ns period
   end

   task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %0s got %h expected %h", sig, got, exp);
         err_count++;
      end
   endtask

   task automatic load_stim(output bit ok);
      int fd, r, n;
      logic [255:0] tok;
      logic [8*160-1:0] skip;
      fx2_word_t w;
      fd = $fopen("sim/pgas_stim.txt", "r");
      ok = (fd != 0);
      if (ok) begin
         while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == 256'("#")) begin
               r = $fgets(skip, fd); // Comment line
            end else begin
               test_name.push_back(tok);
               r = $fscanf(fd, "%d", n);
               req_len.push_back(n);
               for (int i = 0; i < n; i++) begin
                  r = $fscanf(fd, "%h", w);
                  req_words.push_back(w);
               end
               r = $fscanf(fd, "%d", n);
               exp_len.push_back(n);
               for (int i = 0; i < n; i++) begin
                  r = $fscanf(fd, "%h", w);
                  exp_words.push_back(w);
               end
            end
         end
         $fclose(fd);
      end
      cycle_limit = 40 * (req_words.size() + exp_words.size());
   endtask

   // Host side of the FX2, flags change on the rising edge
   always @(posedge clk) begin
      if (rd_fire) void'(host_q.pop_front()); // Word was taken at this edge
      rnd = $random(seed);
      fx2_fd_i          <= (host_q.size() != 0) ? host_q[0] : 16'h0000;
      fx2_epout_empty_i <= (host_q.size() == 0) || (rnd[1:0] == 2'b00);
      fx2_epin_full_i   <= (rnd[3:2] == 2'b00);
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout after %0d cycles, a response did not arrive", cycles);
         $display("Test FAILED");
         $finish;
      end
   end

   // Strobes sampled mid cycle, where they are stable
   always @(negedge clk) begin
      rd_fire = fx2_slrd_o && !fx2_epout_empty_i;
      if (arst_n_i) begin
         if (fx2_slrd_o && fx2_slwr_o) begin
            $display("read and write strobes high together at cycle %0d", cycles);
            err_count++;
         end
         if (fx2_fd_oe_o != fx2_slwr_o) begin
            $display("bus output enable differs from write strobe at cycle %0d", cycles);
            err_count++;
         end
         if (fx2_slrd_o) begin // FX2 drives the bus from EP2
            check_value("fx2_sloe_o", 32'(fx2_sloe_o), 32'd1);
            check_value("fx2_fifoadr_o", 32'(fx2_fifoadr_o), 32'(EP2_ADR));
         end
         if (fx2_slwr_o || fx2_pktend_o) begin // Bridge owns the bus, EP6 selected
            check_value("fx2_sloe_o", 32'(fx2_sloe_o), 32'd0);
            check_value("fx2_fifoadr_o", 32'(fx2_fifoadr_o), 32'(EP6_ADR));
         end
         if (fx2_slwr_o) begin
            got_words.push_back(fx2_fd_o);
            cur_len++;
         end
         if (fx2_pktend_o) begin
            got_len.push_back(cur_len); // Close the packet
            cur_len = 0;
         end
         if (cpu_start_o) start_count++;
      end
   end

   task automatic run_test(input int t, input int ro, input int eo);
      int errs_before, n;
      fx2_word_t val;
      errs_before = err_count;
      for (int i = 0; i < req_len[t]; i++) host_q.push_back(req_words[ro + i]);
      while (got_len.size() == 0) @(posedge clk);
      @(negedge clk);
      n = got_len.pop_front();
      check_value("response length", 32'(n), 32'(exp_len[t]));
      for (int i = 0; i < n; i++) begin
         if (i < exp_len[t]) check_value("fx2_fd_o", 32'(got_words[0]), 32'(exp_words[eo + i]));
         void'(got_words.pop_front());
      end
      // Control register follows a successful REG_CTRL write
      if (exp_words[eo][15:12] == CMD_REG_WR && req_len[t] == 3
          && req_words[ro + 1] == REG_CTRL) begin
         val = req_words[ro + 2];
         halt_exp  = val[CTRL_HALT_BIT];
         reset_exp = val[CTRL_RESET_BIT];
         if (val[CTRL_START_BIT]) start_exp++;
      end
      check_value("sys_halt_o", 32'(sys_halt_o), 32'(halt_exp));
      check_value("cpu_reset_o", 32'(cpu_reset_o), 32'(reset_exp));
      check_value("cpu_start_o pulses", 32'(start_count), 32'(start_exp));
      if (err_count != errs_before) tests_failed++;
      $display("%0s %0s", test_name[t], (err_count == errs_before) ? "passed" : "failed");
   endtask

   initial begin
      int ro, eo, errs_before;
      bit stim_ok;
      arst_n_i          <= 1'b0;
      fx2_fd_i          <= 16'h0000;
      fx2_epout_empty_i <= 1'b1;
      fx2_epin_full_i   <= 1'b0;
      seed = 67;
      err_count = 0;
      tests_failed = 0;
      cycles = 0;
      cur_len = 0;
      start_count = 0;
      start_exp = 0;
      halt_exp = 1'b0;
      reset_exp = 1'b0;
      rd_fire = 1'b0;
      load_stim(stim_ok);
      if (!stim_ok) begin
         $display("cannot open stimulus file sim/pgas_stim.txt");
         $display("Test FAILED");
         $finish;
      end else begin
         repeat (5) @(posedge clk);
         arst_n_i <= 1'b1;
         @(negedge clk);
         errs_before = err_count;
         check_value("fx2_slrd_o", 32'(fx2_slrd_o), 32'd0);
         check_value("fx2_slwr_o", 32'(fx2_slwr_o), 32'd0);
         check_value("fx2_pktend_o", 32'(fx2_pktend_o), 32'd0);
         check_value("fx2_fd_oe_o", 32'(fx2_fd_oe_o), 32'd0);
         check_value("sys_halt_o", 32'(sys_halt_o), 32'd0);
         check_value("cpu_reset_o", 32'(cpu_reset_o), 32'd0);
         check_value("cpu_start_o", 32'(cpu_start_o), 32'd0);
         check_value("wb_cyc", 32'(dut0.wb_cyc), 32'd0);
         check_value("wb_stb", 32'(dut0.wb_stb), 32'd0);
         if (err_count != errs_before) tests_failed++;
         $display("after_reset %0s", (err_count == errs_before) ? "passed" : "failed");
         ro = 0;
         eo = 0;
         for (int t = 0; t < test_name.size(); t++) begin
            run_test(t, ro, eo);
            ro += req_len[t];
            eo += exp_len[t];
         end
         if (got_len.size() != 0 || got_words.size() != 0) begin
            $display("extra response words arrived after the last test");
            err_count++;
         end
         $display("%0d tests, %0d failed, %0d errors", test_name.size() + 1, tests_failed,
                  err_count);
         if (err_count == 0) begin
            $display("Test OK");
         end else begin
            $display("Test FAILED");
         end
         $finish;
      end
   end

endmodule

//--- list.f
verilog/dbg_noc_pkg.sv
verilog/pgas_mem_pkg.sv
verilog/sync_fifo.sv
verilog/usb_fifo_bridge.sv
verilog/dbg_ctrl_unit.sv
verilog/wb_sram_sp.sv
verilog/system_pgas_dbg_top.sv
sim/tb_pgas_dbg.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PGAS debug subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_pgas_dbg -o tb_pgas_dbg
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_pgas_dbg > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Test FAILED" sim.log; then
   exit 1
fi
exit 0

//--- sim/pgas_stim.txt
# name  request_count request_words...  response_count response_words...
# all words hex, SYSTEM_ID ce75, memory 1024 words so byte address bit 12 and up alias
id_rd           2 1001 0000                  2 1001 ce75
ctrl_wr_halt    3 2002 0001 0003             1 2000
ctrl_rd_set     2 1001 0001                  2 1001 0003
ctrl_wr_start   3 2002 0001 0004             1 2000
ctrl_rd_clear   2 1001 0001                  2 1001 0000
ctrl_wr_halt_only 3 2002 0001 0001           1 2000
mem_wr_a        5 4004 0000 0010 1234 5678   1 4000
mem_wr_b        5 4004 0000 0100 cafe f00d   1 4000
mem_rd_a        3 3002 0000 0010             3 3002 1234 5678
mem_rd_alias_a  3 3002 0000 1010             3 3002 1234 5678
mem_rd_b        3 3002 0000 0100             3 3002 cafe f00d
mem_wr_alias_b  5 4004 0001 0100 dead beef   1 4000
mem_rd_b_new    3 3002 0000 0100             3 3002 dead beef
mem_wr_c        5 4004 0000 0ffc 0bad f00d   1 4000
mem_rd_c_alias  3 3002 8000 1ffc             3 3002 0bad f00d
bad_cmd         1 7000                       1 f000
id_rd_after_cmd 2 1001 0000                  2 1001 ce75
bad_count       3 1002 0000 0001             1 f000
bad_count_zero  1 4000                       1 f000
bad_reg         2 1001 0005                  1 f000
ctrl_rd_after   2 1001 0001                  2 1001 0001
mem_rd_after    3 3002 0000 0010             3 3002 1234 5678
